//--- Bender.yml
package:
  name: idct_frame

sources:
  - idct_pkg.sv
  - sram_map_pkg.sv
  - c_coeff_rom.sv
  - block_ram.sv
  - block_fetch.sv
  - idct_engine.sv
  - block_writeback.sv
  - idct_top.sv
  - target: test
    files:
      - idct_assertions.sv
      - tb_idct_top.sv

//--- block_fetch.sv
/*
 * Frame sequencer. Walks the blocks in raster order, streams one block of
 * coefficients from SRAM into the coefficient RAM per block and pulses
 * frame_done_o after the last block has been written back.
 */
`timescale 1ns/10ps

module block_fetch (
	input  logic                    Clock,
	input  logic                    Resetn,
	input  logic                    start_i,
	input  logic                    wb_done_i,
	output sram_map_pkg::sram_addr_t sram_addr_o,
	input  sram_map_pkg::sram_data_t sram_read_data_i,
	output logic                    ram_wr_en_o,
	output idct_pkg::ram_addr_t     ram_wr_addr_o,
	output idct_pkg::acc_t          ram_wr_data_o,
	output logic                    fetch_done_o,
	output logic [1:0]              blk_x_o,
	output logic [1:0]              blk_y_o,
	output logic                    frame_done_o
);

	idct_pkg::fetch_state_t state;
	idct_pkg::ram_addr_t rd_cnt;	// coefficient being requested
	logic [sram_map_pkg::SRAM_READ_LATENCY-1:0] vld_pipe;
	logic last_blk;

	assign sram_addr_o = sram_map_pkg::COEF_BASE
		+ sram_map_pkg::sram_addr_t'({blk_y_o, rd_cnt[5:3]}) * sram_map_pkg::COEF_ROW_STRIDE
		+ sram_map_pkg::sram_addr_t'({blk_x_o, rd_cnt[2:0]});

	// data of a read lines up with the tail of the valid pipe
	assign ram_wr_en_o = vld_pipe[sram_map_pkg::SRAM_READ_LATENCY-1];
	assign ram_wr_data_o = idct_pkg::acc_t'(idct_pkg::sample_t'(sram_read_data_i));

	assign last_blk = (blk_x_o == 2'(sram_map_pkg::IMG_BLOCKS_X - 1))
		&& (blk_y_o == 2'(sram_map_pkg::IMG_BLOCKS_Y - 1));

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= idct_pkg::F_IDLE;
			rd_cnt <= '0;
			vld_pipe <= '0;
			ram_wr_addr_o <= '0;
			blk_x_o <= '0;
			blk_y_o <= '0;
			fetch_done_o <= 1'b0;
			frame_done_o <= 1'b0;
		end else begin
			fetch_done_o <= 1'b0;
			frame_done_o <= 1'b0;
			vld_pipe <= {vld_pipe[sram_map_pkg::SRAM_READ_LATENCY-2:0],
				(state == idct_pkg::F_READ)};
			if (ram_wr_en_o) begin
				ram_wr_addr_o <= ram_wr_addr_o + 6'd1;	// wraps to 0 after each block
			end
			case (state)
				idct_pkg::F_IDLE: begin
					if (start_i) begin
						blk_x_o <= '0;
						blk_y_o <= '0;
						rd_cnt <= '0;
						ram_wr_addr_o <= '0;
						state <= idct_pkg::F_READ;
					end
				end
				idct_pkg::F_READ: begin
					rd_cnt <= rd_cnt + 6'd1;
					if (rd_cnt == 6'd63) begin
						state <= idct_pkg::F_DRAIN;
					end
				end
				idct_pkg::F_DRAIN: begin
					if (ram_wr_en_o && (ram_wr_addr_o == 6'd63)) begin
						fetch_done_o <= 1'b1;
						state <= idct_pkg::F_WAIT;
					end
				end
				idct_pkg::F_WAIT: begin
					if (wb_done_i) begin
						if (last_blk) begin
							frame_done_o <= 1'b1;
							state <= idct_pkg::F_IDLE;
						end else begin
							// raster order, x first
							if (blk_x_o == 2'(sram_map_pkg::IMG_BLOCKS_X - 1)) begin
								blk_x_o <= '0;
								blk_y_o <= blk_y_o + 2'd1;
							end else begin
								blk_x_o <= blk_x_o + 2'd1;
							end
							rd_cnt <= '0;
							state <= idct_pkg::F_READ;
						end
					end
				end
				default: state <= idct_pkg::F_IDLE;
			endcase
		end
	end

endmodule

//--- block_ram.sv
/*
 * 64 x 32 simple dual-port RAM for one 8x8 block.
 * Registered read, one cycle latency, read-during-write gives old data.
 */
`timescale 1ns/10ps

module block_ram (
	input  logic                Clock,
	input  logic                wr_en_i,
	input  idct_pkg::ram_addr_t wr_addr_i,
	input  idct_pkg::acc_t      wr_data_i,
	input  idct_pkg::ram_addr_t rd_addr_i,
	output idct_pkg::acc_t      rd_data_o
);

	idct_pkg::acc_t mem [64];

	always_ff @(posedge Clock) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

//--- block_writeback.sv
/*
 * Reads the 64 clipped pixels of a block in row order and writes them to
 * the pixel region of SRAM as {even, odd} pairs, 32 words per block.
 */
`timescale 1ns/10ps

module block_writeback (
	input  logic                     Clock,
	input  logic                     Resetn,
	input  logic                     start_i,
	input  logic [1:0]               blk_x_i,
	input  logic [1:0]               blk_y_i,
	output idct_pkg::ram_addr_t      pix_rd_addr_o,
	input  idct_pkg::acc_t           pix_rd_data_i,
	output sram_map_pkg::sram_addr_t sram_addr_o,
	output sram_map_pkg::sram_data_t sram_write_data_o,
	output logic                     sram_write_o,
	output logic                     done_o
);

	idct_pkg::wb_state_t state;
	idct_pkg::ram_addr_t rd_cnt;
	idct_pkg::ram_addr_t data_idx;	// pixel index of pix_rd_data_i
	logic data_vld;
	idct_pkg::pixel_t even_pix;

	assign pix_rd_addr_o = rd_cnt;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= idct_pkg::W_IDLE;
			rd_cnt <= '0;
			data_vld <= 1'b0;
			sram_write_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			data_vld <= (state == idct_pkg::W_READ);
			sram_write_o <= data_vld && data_idx[0];	// odd pixel completes a pair
			case (state)
				idct_pkg::W_IDLE: begin
					if (start_i) begin
						rd_cnt <= '0;
						state <= idct_pkg::W_READ;
					end
				end
				idct_pkg::W_READ: begin
					rd_cnt <= rd_cnt + 6'd1;
					if (rd_cnt == 6'd63) begin
						state <= idct_pkg::W_DRAIN;
					end
				end
				idct_pkg::W_DRAIN: state <= idct_pkg::W_DONE;
				idct_pkg::W_DONE: begin	// last word on the bus
					done_o <= 1'b1;
					state <= idct_pkg::W_IDLE;
				end
				default: state <= idct_pkg::W_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		data_idx <= rd_cnt;
		if (data_vld) begin
			if (!data_idx[0]) begin
				even_pix <= pix_rd_data_i[7:0];
			end else begin
				sram_write_data_o <= {even_pix, pix_rd_data_i[7:0]};
				sram_addr_o <= sram_map_pkg::PIX_BASE
					+ sram_map_pkg::sram_addr_t'({blk_y_i, data_idx[5:3]})
						* sram_map_pkg::PIX_ROW_STRIDE
					+ sram_map_pkg::sram_addr_t'({blk_x_i, data_idx[2:1]});
			end
		end
	end

endmodule

//--- c_coeff_rom.sv
/*
 * Cosine lookup with two independent read ports, one per multiplier.
 * Purely combinational, index is (k, j) into the C matrix.
 */
`timescale 1ns/10ps

module c_coeff_rom (
	input  logic [2:0]       row0_i,
	input  logic [2:0]       col0_i,
	input  logic [2:0]       row1_i,
	input  logic [2:0]       col1_i,
	output idct_pkg::coeff_t c0_o,
	output idct_pkg::coeff_t c1_o
);

	logic [5:0] idx0;
	logic [5:0] idx1;

	assign idx0 = {row0_i, col0_i};	// k*8 + j
	assign idx1 = {row1_i, col1_i};

	assign c0_o = idct_pkg::C_MATRIX[idx0];
	assign c1_o = idct_pkg::C_MATRIX[idx1];

endmodule

//--- compile.f
idct_pkg.sv
sram_map_pkg.sv
c_coeff_rom.sv
block_ram.sv
block_fetch.sv
idct_engine.sv
block_writeback.sv
idct_top.sv
idct_assertions.sv
tb_idct_top.sv

//--- idct_assertions.sv
/*
 * Concurrent checks on the SRAM bus and the control pulses of idct_top,
 * attached to every idct_top instance by the bind below.
 */
`timescale 1ns/10ps

module idct_assertions (
	input logic                     Clock,
	input logic                     Resetn,
	input logic                     sram_we_n_i,
	input sram_map_pkg::sram_addr_t sram_address_i,
	input logic                     done_i,
	input logic                     fetch_done_i,
	input logic                     idct_done_i,
	input logic                     wb_done_i,
	input logic                     coef_wr_en_i,
	input logic                     t_wr_en_i,
	input logic                     pix_wr_en_i
);

	int fail_count = 0;

	a_write_in_pix_region: assert property (@(posedge Clock) disable iff (!Resetn)
		!sram_we_n_i |-> sram_address_i >= sram_map_pkg::PIX_BASE)
		else begin
			fail_count++;
			$error("SRAM write below the pixel region");
		end

	a_done_pulse: assert property (@(posedge Clock) disable iff (!Resetn) done_i |=> !done_i)
		else begin
			fail_count++;
			$error("done_o high for more than one cycle");
		end

	a_internal_pulses: assert property (@(posedge Clock) disable iff (!Resetn)
		(fetch_done_i || idct_done_i || wb_done_i) |=> !(fetch_done_i || idct_done_i || wb_done_i))
		else begin
			fail_count++;
			$error("controller start pulse longer than one cycle");
		end

	// second cycle of reset, flops settled
	a_ram_we_in_reset: assert property (@(posedge Clock)
		(!Resetn && $past(!Resetn)) |-> !(coef_wr_en_i || t_wr_en_i || pix_wr_en_i))
		else begin
			fail_count++;
			$error("block RAM write enable high in reset");
		end

endmodule

bind idct_top idct_assertions i_assertions (
	.Clock(Clock), .Resetn(Resetn),
	.sram_we_n_i(sram_we_n_o), .sram_address_i(sram_address_o), .done_i(done_o),
	.fetch_done_i(fetch_done), .idct_done_i(idct_done), .wb_done_i(wb_done),
	.coef_wr_en_i(coef_wr_en), .t_wr_en_i(t_wr_en), .pix_wr_en_i(pix_wr_en)
);

//--- idct_engine.sv
/*
 * Two-pass 8x8 IDCT with two multipliers. Pass 1 writes T transposed into
 * t_ram so both passes read a source row and produce C[k][o] weighted sums.
 * Pass 2 shifts, clips to 0..255 and writes pixels row-major.
 */
`timescale 1ns/10ps

module idct_engine (
	input  logic                Clock,
	input  logic                Resetn,
	input  logic                start_i,
	output idct_pkg::ram_addr_t coef_rd_addr_o,
	input  idct_pkg::acc_t      coef_rd_data_i,
	output logic                t_wr_en_o,
	output idct_pkg::ram_addr_t t_wr_addr_o,
	output idct_pkg::acc_t      t_wr_data_o,
	output idct_pkg::ram_addr_t t_rd_addr_o,
	input  idct_pkg::acc_t      t_rd_data_i,
	output logic                pix_wr_en_o,
	output idct_pkg::ram_addr_t pix_wr_addr_o,
	output idct_pkg::acc_t      pix_wr_data_o,
	output logic                done_o
);

	idct_pkg::engine_state_t state;
	logic pass2;
	logic [7:0] cyc;	// {source row, output index, product pair}
	logic [3:0] ld_cnt;
	logic [2:0] r;
	logic [2:0] o;
	logic [1:0] kp;
	logic calc_last;
	idct_pkg::acc_t row_buf [8];
	idct_pkg::acc_t nxt_buf [8];	// next source row, prefetched during calc
	idct_pkg::acc_t src_data;
	idct_pkg::acc_t acc;
	idct_pkg::acc_t prod0;
	idct_pkg::acc_t prod1;
	idct_pkg::acc_t mac_sum;
	idct_pkg::acc_t t_val;
	idct_pkg::acc_t pix_shift;
	idct_pkg::coeff_t c0;
	idct_pkg::coeff_t c1;
	idct_pkg::pixel_t pix_val;
	idct_pkg::ram_addr_t rd_addr;
	idct_pkg::ram_addr_t wr_addr;
	idct_pkg::acc_t wr_data;

	assign {r, o, kp} = cyc;
	assign calc_last = (state == idct_pkg::E_CALC) && (kp == 2'd3);

	// row 0 while loading, otherwise the row after the current one
	assign rd_addr = (state == idct_pkg::E_LOAD) ? {3'd0, ld_cnt[2:0]} : {r + 3'd1, o};
	assign coef_rd_addr_o = rd_addr;
	assign t_rd_addr_o = rd_addr;
	assign src_data = pass2 ? t_rd_data_i : coef_rd_data_i;

	c_coeff_rom u_rom (
		.row0_i ({kp, 1'b0}),
		.col0_i (o),
		.row1_i ({kp, 1'b1}),
		.col1_i (o),
		.c0_o   (c0),
		.c1_o   (c1)
	);

	assign prod0 = row_buf[{kp, 1'b0}] * c0;
	assign prod1 = row_buf[{kp, 1'b1}] * c1;
	assign mac_sum = acc + prod0 + prod1;
	assign t_val = mac_sum >>> idct_pkg::PASS1_SHIFT;
	assign pix_shift = mac_sum >>> idct_pkg::PASS2_SHIFT;

	always_comb begin
		if (pix_shift < 0)
			pix_val = 8'd0;
		else if (pix_shift > 255)
			pix_val = 8'd255;
		else
			pix_val = pix_shift[7:0];
	end

	assign t_wr_addr_o = wr_addr;
	assign t_wr_data_o = wr_data;
	assign pix_wr_addr_o = wr_addr;
	assign pix_wr_data_o = wr_data;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= idct_pkg::E_IDLE;
			pass2 <= 1'b0;
			cyc <= '0;
			ld_cnt <= '0;
			t_wr_en_o <= 1'b0;
			pix_wr_en_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			t_wr_en_o <= calc_last && !pass2;
			pix_wr_en_o <= calc_last && pass2;
			case (state)
				idct_pkg::E_IDLE: begin
					if (start_i) begin
						pass2 <= 1'b0;
						ld_cnt <= '0;
						state <= idct_pkg::E_LOAD;
					end
				end
				idct_pkg::E_LOAD: begin
					ld_cnt <= ld_cnt + 4'd1;
					if (ld_cnt == 4'd8) begin
						cyc <= '0;
						state <= idct_pkg::E_CALC;
					end
				end
				idct_pkg::E_CALC: begin
					cyc <= cyc + 8'd1;
					if (cyc == 8'hff) begin
						if (pass2) begin
							state <= idct_pkg::E_DRAIN;
						end else begin
							pass2 <= 1'b1;
							ld_cnt <= '0;
							state <= idct_pkg::E_LOAD;
						end
					end
				end
				idct_pkg::E_DRAIN: begin	// last pixel write in this cycle
					done_o <= 1'b1;
					state <= idct_pkg::E_IDLE;
				end
				default: state <= idct_pkg::E_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (calc_last) begin
			wr_addr <= {o, r};	// transposed store
			wr_data <= pass2 ? idct_pkg::acc_t'(pix_val) : t_val;
		end
		if ((state == idct_pkg::E_LOAD) && (ld_cnt != 4'd0)) begin
			row_buf[ld_cnt[2:0] - 3'd1] <= src_data;	// entry 7 when ld_cnt is 8
		end
		if (state == idct_pkg::E_CALC) begin
			acc <= (kp == 2'd3) ? '0 : mac_sum;
			if (kp == 2'd1) begin
				nxt_buf[o] <= src_data;
			end
			if ((o == 3'd7) && (kp == 2'd3)) begin
				row_buf <= nxt_buf;
			end
		end else begin
			acc <= '0;
		end
	end

endmodule

//--- idct_pkg.sv
/*
 * IDCT datapath types, the fixed-point cosine matrix and the controller
 * state encodings, shared by the engine, the fetch and write-back blocks
 */
package idct_pkg;

	typedef logic signed [15:0] sample_t;	// dequantized coefficient from SRAM
	typedef logic signed [15:0] coeff_t;	// cosine constant, x4096
	typedef logic signed [31:0] acc_t;	// product sum and block RAM word
	typedef logic [7:0] pixel_t;
	typedef logic [5:0] ram_addr_t;	// row * 8 + column

	// C[k][j] at index k*8 + j
	localparam coeff_t C_MATRIX [64] = '{
		1448,  2009,  1892,  1703,  1448,  1138,   784,   400,
		1448,  1703,   784,  -400, -1448, -2009, -1892, -1138,
		1448,  1138,  -784, -2009, -1448,   400,  1892,  1703,
		1448,   400, -1892, -1138,  1448,  1703,  -784, -2009,
		1448,  -400, -1892,  1138,  1448, -1703,  -784,  2009,
		1448, -1138,  -784,  2009, -1448,  -400,  1892, -1703,
		1448, -1703,   784,   400, -1448,  2009, -1892,  1138,
		1448, -2009,  1892, -1703,  1448, -1138,   784,  -400
	};

	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;

	typedef enum logic [1:0] {
		F_IDLE,
		F_READ,
		F_DRAIN,	// waiting for the last words from SRAM
		F_WAIT		// block in flight through engine and write-back
	} fetch_state_t;

	typedef enum logic [1:0] {E_IDLE, E_LOAD, E_CALC, E_DRAIN} engine_state_t;

	typedef enum logic [1:0] {W_IDLE, W_READ, W_DRAIN, W_DONE} wb_state_t;

endpackage

//--- idct_top.sv
/*
 * Frame IDCT top level. Fetch, engine and write-back run one after the
 * other per block and share the single SRAM port.
 */
`timescale 1ns/10ps

module idct_top (
	input  logic                     Clock,
	input  logic                     Resetn,
	input  logic                     start_i,
	output sram_map_pkg::sram_addr_t sram_address_o,
	input  sram_map_pkg::sram_data_t sram_read_data_i,
	output sram_map_pkg::sram_data_t sram_write_data_o,
	output logic                     sram_we_n_o,
	output logic                     done_o
);

	logic fetch_done, idct_done, wb_done;
	logic [1:0] blk_x, blk_y;
	logic wb_write;
	sram_map_pkg::sram_addr_t fetch_sram_addr, wb_sram_addr;

	logic coef_wr_en, t_wr_en, pix_wr_en;
	idct_pkg::ram_addr_t coef_wr_addr, coef_rd_addr, t_wr_addr, t_rd_addr;
	idct_pkg::ram_addr_t pix_wr_addr, pix_rd_addr;
	idct_pkg::acc_t coef_wr_data, coef_rd_data, t_wr_data, t_rd_data;
	idct_pkg::acc_t pix_wr_data, pix_rd_data;

	// write-back owns the bus only while writing
	assign sram_address_o = wb_write ? wb_sram_addr : fetch_sram_addr;
	assign sram_we_n_o = ~wb_write;

	block_fetch u_fetch (
		.Clock(Clock), .Resetn(Resetn),
		.start_i(start_i), .wb_done_i(wb_done),
		.sram_addr_o(fetch_sram_addr), .sram_read_data_i(sram_read_data_i),
		.ram_wr_en_o(coef_wr_en), .ram_wr_addr_o(coef_wr_addr), .ram_wr_data_o(coef_wr_data),
		.fetch_done_o(fetch_done), .blk_x_o(blk_x), .blk_y_o(blk_y),
		.frame_done_o(done_o)
	);

	idct_engine u_engine (
		.Clock(Clock), .Resetn(Resetn), .start_i(fetch_done),
		.coef_rd_addr_o(coef_rd_addr), .coef_rd_data_i(coef_rd_data),
		.t_wr_en_o(t_wr_en), .t_wr_addr_o(t_wr_addr), .t_wr_data_o(t_wr_data),
		.t_rd_addr_o(t_rd_addr), .t_rd_data_i(t_rd_data),
		.pix_wr_en_o(pix_wr_en), .pix_wr_addr_o(pix_wr_addr), .pix_wr_data_o(pix_wr_data),
		.done_o(idct_done)
	);

	block_writeback u_writeback (
		.Clock(Clock), .Resetn(Resetn), .start_i(idct_done),
		.blk_x_i(blk_x), .blk_y_i(blk_y),
		.pix_rd_addr_o(pix_rd_addr), .pix_rd_data_i(pix_rd_data),
		.sram_addr_o(wb_sram_addr), .sram_write_data_o(sram_write_data_o),
		.sram_write_o(wb_write), .done_o(wb_done)
	);

	block_ram coef_ram (
		.Clock(Clock), .wr_en_i(coef_wr_en), .wr_addr_i(coef_wr_addr),
		.wr_data_i(coef_wr_data), .rd_addr_i(coef_rd_addr), .rd_data_o(coef_rd_data)
	);

	block_ram t_ram (
		.Clock(Clock), .wr_en_i(t_wr_en), .wr_addr_i(t_wr_addr),
		.wr_data_i(t_wr_data), .rd_addr_i(t_rd_addr), .rd_data_o(t_rd_data)
	);

	block_ram pix_ram (
		.Clock(Clock), .wr_en_i(pix_wr_en), .wr_addr_i(pix_wr_addr),
		.wr_data_i(pix_wr_data), .rd_addr_i(pix_rd_addr), .rd_data_o(pix_rd_data)
	);

endmodule

//--- sram_map_pkg.sv
/*
 * External SRAM layout for one luminance frame: coefficient and pixel
 * regions, image size in 8x8 blocks and the read latency of the part
 */
package sram_map_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;

	localparam int IMG_BLOCKS_X = 2;
	localparam int IMG_BLOCKS_Y = 2;

	localparam sram_addr_t COEF_BASE = 18'd0;	// one coefficient per word
	localparam sram_addr_t PIX_BASE = 18'd1024;	// two pixels per word, even col high

	localparam sram_addr_t COEF_ROW_STRIDE = sram_addr_t'(IMG_BLOCKS_X * 8);
	localparam sram_addr_t PIX_ROW_STRIDE = sram_addr_t'(IMG_BLOCKS_X * 4);

	localparam int SRAM_READ_LATENCY = 2;

endpackage

//--- tb_idct_top.sv
/*
 * Testbench for idct_top with a behavioral SRAM, a reference two-pass IDCT
 * model and directed frame tests. Top module is tb_idct_top.
 */
`timescale 1ns/10ps

module tb_idct_top;

	localparam int NBLK = sram_map_pkg::IMG_BLOCKS_X * sram_map_pkg::IMG_BLOCKS_Y;
	localparam int LAT = sram_map_pkg::SRAM_READ_LATENCY;
	localparam int MEM_WORDS = 2048;
	localparam int FRAME_TIMEOUT = 20000;

	logic Clock;
	logic Resetn;
	logic start_i;
	sram_map_pkg::sram_addr_t sram_address;
	sram_map_pkg::sram_data_t sram_read_data;
	sram_map_pkg::sram_data_t sram_write_data;
	logic sram_we_n;
	logic done;

	sram_map_pkg::sram_data_t sram_mem [MEM_WORDS];
	sram_map_pkg::sram_data_t rd_pipe [LAT];
	int coef_writes;	// writes below PIX_BASE
	int range_errors;
	int coef_blk [NBLK][64];
	int exp_pix [NBLK][64];
	int errors;
	int checks;
	int seed;
	logic aborted;

	idct_top i_dut (
		.Clock(Clock), .Resetn(Resetn), .start_i(start_i),
		.sram_address_o(sram_address), .sram_read_data_i(sram_read_data),
		.sram_write_data_o(sram_write_data), .sram_we_n_o(sram_we_n), .done_o(done)
	);

	always #50 Clock = ~Clock;

	assign sram_read_data = rd_pipe[LAT-1];

	// one register per cycle of read latency
	always @(posedge Clock) begin
		rd_pipe[0] <= sram_mem[sram_address[10:0]];
		for (int i = 1; i < LAT; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
		if (!sram_we_n) begin
			if (sram_address >= MEM_WORDS)
				range_errors++;
			else
				sram_mem[sram_address[10:0]] <= sram_write_data;
			if (sram_address < sram_map_pkg::PIX_BASE)
				coef_writes++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	function automatic int clip_pixel(input int v);
		if (v < 0)
			return 0;
		if (v > 255)
			return 255;
		return v;
	endfunction

	function automatic int coef_addr(input int b, input int idx);
		int bx;
		int by;
		bx = b % sram_map_pkg::IMG_BLOCKS_X;
		by = b / sram_map_pkg::IMG_BLOCKS_X;
		return int'(sram_map_pkg::COEF_BASE) + (by * 8 + idx / 8) * sram_map_pkg::IMG_BLOCKS_X * 8
			+ bx * 8 + idx % 8;
	endfunction

	function automatic int pix_addr(input int b, input int idx);
		int bx;
		int by;
		bx = b % sram_map_pkg::IMG_BLOCKS_X;
		by = b / sram_map_pkg::IMG_BLOCKS_X;
		return int'(sram_map_pkg::PIX_BASE) + (by * 8 + idx / 8) * sram_map_pkg::IMG_BLOCKS_X * 4
			+ bx * 4 + (idx % 8) / 2;
	endfunction

	// T = S' * C row by row, then S = C^T * T, each with its own shift
	task automatic model_frame;
		int t [64];
		int sum;
		for (int b = 0; b < NBLK; b++) begin
			for (int i = 0; i < 8; i++) begin
				for (int j = 0; j < 8; j++) begin
					sum = 0;
					for (int k = 0; k < 8; k++)
						sum += coef_blk[b][i*8+k] * int'(idct_pkg::C_MATRIX[k*8+j]);
					t[i*8+j] = sum >>> idct_pkg::PASS1_SHIFT;
				end
			end
			for (int i = 0; i < 8; i++) begin
				for (int j = 0; j < 8; j++) begin
					sum = 0;
					for (int k = 0; k < 8; k++)
						sum += int'(idct_pkg::C_MATRIX[k*8+i]) * t[k*8+j];
					exp_pix[b][i*8+j] = clip_pixel(sum >>> idct_pkg::PASS2_SHIFT);
				end
			end
		end
	endtask

	task automatic clear_blocks;
		for (int b = 0; b < NBLK; b++)
			for (int idx = 0; idx < 64; idx++)
				coef_blk[b][idx] = 0;
	endtask

	// address-dependent fill, then the coefficients on top
	task automatic load_frame;
		for (int a = 0; a < MEM_WORDS; a++)
			sram_mem[a] = 16'(a * 40503) ^ 16'h5a3c;
		for (int b = 0; b < NBLK; b++)
			for (int idx = 0; idx < 64; idx++)
				sram_mem[coef_addr(b, idx)] = 16'(coef_blk[b][idx]);
		coef_writes = 0;
	endtask

	task automatic pulse_start;
		@(posedge Clock);
		start_i <= 1'b1;
		@(posedge Clock);
		start_i <= 1'b0;
	endtask

	task automatic run_frame;
		int cycles;
		int pulses;
		pulse_start();
		cycles = 0;
		pulses = 0;
		while (pulses == 0 && cycles < FRAME_TIMEOUT) begin
			@(posedge Clock);
			cycles++;
			if (done)
				pulses++;
		end
		if (pulses == 0) begin
			report_failure("timeout waiting for done_o at the end of the frame");
			aborted = 1'b1;
			return;
		end
		repeat (16) begin
			@(posedge Clock);
			if (done)
				pulses++;
		end
		check_value("done_o pulse count", pulses, 1);
	endtask

	task automatic check_frame;
		int addr;
		int expected;
		model_frame();
		for (int b = 0; b < NBLK; b++) begin
			for (int idx = 0; idx < 64; idx += 2) begin
				addr = pix_addr(b, idx);
				expected = (exp_pix[b][idx] << 8) | exp_pix[b][idx+1];	// even column high
				check_value($sformatf("sram[0x%0h]", addr), sram_mem[addr], expected);
			end
		end
		check_value("coefficient region writes", coef_writes, 0);
		check_value("out of range writes", range_errors, 0);
	endtask

	task automatic run_and_check;
		load_frame();
		run_frame();
		if (!aborted)
			check_frame();
	endtask

	task automatic all_zero_frame;
		clear_blocks();
		run_and_check();
	endtask

	task automatic single_dc_block;
		clear_blocks();
		coef_blk[0][0] = 1024;
		run_and_check();
	endtask

	task automatic dc_clipping;
		clear_blocks();
		coef_blk[0][0] = 16000;
		coef_blk[NBLK-1][0] = -16000;
		run_and_check();
		if (!aborted) begin
			check_value("block 0 pixel (0,0)", sram_mem[pix_addr(0, 0)][15:8], 255);
			check_value("last block pixel (0,0)", sram_mem[pix_addr(NBLK-1, 0)][15:8], 0);
		end
	endtask

	task automatic random_coefficients;
		for (int b = 0; b < NBLK; b++)
			for (int idx = 0; idx < 64; idx++)
				coef_blk[b][idx] = ($random(seed) & 511) - 256;	// -256 .. 255
		run_and_check();
	endtask

	// same coefficients twice, pixel region refilled in between
	task automatic repeated_frame;
		run_and_check();
		if (!aborted)
			run_and_check();
	endtask

	task automatic reset_during_frame;
		int cycles;
		load_frame();
		pulse_start();
		cycles = 0;
		while (sram_we_n !== 1'b0 && cycles < FRAME_TIMEOUT) begin
			@(posedge Clock);
			cycles++;
		end
		if (sram_we_n !== 1'b0) begin
			report_failure("timeout waiting for the first pixel write");
			aborted = 1'b1;
			return;
		end
		Resetn <= 1'b0;
		repeat (4) begin
			@(posedge Clock);
			check_value("done_o in reset", done, 0);
			check_value("sram_we_n_o in reset", sram_we_n, 1);
		end
		Resetn <= 1'b1;
		repeat (4) begin
			@(posedge Clock);
			check_value("done_o after reset", done, 0);
			check_value("sram_we_n_o after reset", sram_we_n, 1);
		end
		run_and_check();
	endtask

	initial begin
		Clock = 1'b0;
		Resetn = 1'b0;
		start_i = 1'b0;
		for (int i = 0; i < LAT; i++)
			rd_pipe[i] = '0;
		errors = 0;
		checks = 0;
		coef_writes = 0;
		range_errors = 0;
		aborted = 1'b0;
		seed = 25919;
		repeat (10) @(posedge Clock);
		Resetn <= 1'b1;
		all_zero_frame();
		if (!aborted)
			single_dc_block();
		if (!aborted)
			dc_clipping();
		if (!aborted)
			random_coefficients();
		if (!aborted)
			repeated_frame();
		if (!aborted)
			reset_during_frame();
		errors += i_dut.i_assertions.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
